// ==== verilog/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    // ========================================================================
    // Bus geometry
    // ========================================================================
    localparam int WB_ADDR_W   = 32;
    localparam int WB_DATA_W   = 32;
    // Upper address half picks the slave
    localparam int WB_REGION_W = 16;

    // Slave regions, one per 64K window
    typedef enum logic [WB_REGION_W-1:0] {
        // I2C/SPI masters, not fitted in this build
        REGION_SI571   = 16'd1,
        REGION_AD9510  = 16'd2,
        REGION_EEPROM  = 16'd3,
        REGION_LM75    = 16'd4,
        // Card control and status
        REGION_FMC_CSR = 16'd5
    } wb_region_e;

endpackage

`default_nettype wire

// ==== verilog/fmc_pkg.sv ====
`default_nettype none

package fmc_pkg;

    // ========================================================================
    // ADC front end
    // ========================================================================
    localparam int ADC_CHANNELS = 4;
    localparam int ADC_SAMPLE_W = 16;
    localparam int DATA_WORD_W  = 32;
    // Overflow flag sits just above the sample
    localparam int DATA_OF_BIT  = 16;

    localparam logic [31:0] FIRMWARE_ID = 32'h01332A11;

    // Word offset comes from address bits 5..2
    localparam int CSR_REG_LSB = 2;

    typedef enum logic [3:0] {
        FMC_STATUS  = 4'd0,
        FW_ID       = 4'd1,
        TRIGGER     = 4'd2,
        ADC_CTRL    = 4'd3,
        CLK_DISTRIB = 4'd4,
        MONITOR     = 4'd5,
        FPGA_CTRL   = 4'd6,
        DATA0       = 4'd7,
        DATA1       = 4'd8,
        DATA2       = 4'd9,
        DATA3       = 4'd10
    } csr_reg_e;

    // ========================================================================
    // Register bit positions
    // ========================================================================
    localparam int STATUS_PRSNT_BIT     = 0;
    localparam int STATUS_PG_BIT        = 1;
    localparam int TRIG_DIR_BIT         = 0;
    localparam int TRIG_TERM_BIT        = 1;
    localparam int TRIG_VAL_BIT         = 2;
    localparam int ADC_RAND_BIT         = 0;
    localparam int ADC_DITH_BIT         = 1;
    localparam int ADC_SHDN_BIT         = 2;
    localparam int ADC_PGA_BIT          = 3;
    localparam int CLK_SI571_OE_BIT     = 0;
    localparam int CLK_PLL_FUNC_BIT     = 1;
    // Read only
    localparam int CLK_PLL_STATUS_BIT   = 2;
    localparam int CLK_SEL_BIT          = 3;
    // Read only
    localparam int MON_TEMP_ALARM_BIT   = 0;
    localparam int MON_LED1_BIT         = 1;
    localparam int MON_LED2_BIT         = 2;
    localparam int MON_LED3_BIT         = 3;
    localparam int FPGA_CAPTURE_CLR_BIT = 0;

endpackage

`default_nettype wire

// ==== verilog/wb_addr_decode.sv ====
`default_nettype none

module wb_addr_decode (
    input  wire                             wb_clk_i,
    input  wire                             rst_n_i,
    input  wire                             wb_cyc_i,
    input  wire                             wb_stb_i,
    // Region field only
    input  wire [wb_pkg::WB_REGION_W-1:0]   wb_adr_i,
    input  wire                             csr_ack_i,
    input  wire [wb_pkg::WB_DATA_W-1:0]     csr_dat_i,
    output logic                            csr_stb_o,
    output logic                            wb_ack_o,
    output logic                            wb_err_o,
    output logic [wb_pkg::WB_DATA_W-1:0]    wb_dat_o
);

    import wb_pkg::*;

    wb_region_e region;
    logic       bus_req;
    logic       csr_hit;
    logic       err_q;

    assign region  = wb_region_e'(wb_adr_i);
    assign bus_req = wb_cyc_i && wb_stb_i;

    // ========================================================================
    // Region match
    // ========================================================================
    always_comb begin
        case (region)
            REGION_FMC_CSR: begin
                csr_hit = 1'b1;
            end
            // Serial bus masters removed, these fall into the error path
            REGION_SI571, REGION_AD9510, REGION_EEPROM, REGION_LM75: begin
                csr_hit = 1'b0;
            end
            default: begin
                csr_hit = 1'b0;
            end
        endcase
    end

    assign csr_stb_o = bus_req && csr_hit;

    // Error pulse for anything not mapped
    // Held strobe must not raise a second pulse
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= bus_req && !csr_hit && !err_q;
        end
    end

    assign wb_err_o = err_q;

    // Single live slave, ack passes straight through
    assign wb_ack_o = csr_ack_i;
    // Quiet data bus outside the ack cycle
    assign wb_dat_o = csr_ack_i ? csr_dat_i : '0;

endmodule

`default_nettype wire

// ==== verilog/adc_capture.sv ====
`default_nettype none

module adc_capture (
    input  wire                                                    wb_clk_i,
    input  wire                                                    rst_n_i,
    input  wire [fmc_pkg::ADC_CHANNELS-1:0][fmc_pkg::ADC_SAMPLE_W-1:0] adc_data_i,
    input  wire [fmc_pkg::ADC_CHANNELS-1:0]                        adc_of_i,
    input  wire                                                    adc_valid_i,
    input  wire                                                    capture_clr_i,
    output logic [fmc_pkg::ADC_CHANNELS-1:0][fmc_pkg::DATA_WORD_W-1:0] data_words_o
);

    import fmc_pkg::*;

    logic [ADC_CHANNELS-1:0][DATA_WORD_W-1:0] word_next;

    // ========================================================================
    // Word packing
    // ========================================================================
    // Sample in the low half, overflow at DATA_OF_BIT, rest zero
    always_comb begin
        for (int ch = 0; ch < ADC_CHANNELS; ch++) begin
            word_next[ch]                     = '0;
            word_next[ch][ADC_SAMPLE_W-1:0]   = adc_data_i[ch];
            word_next[ch][DATA_OF_BIT]        = adc_of_i[ch];
        end
    end

    // Clear wins over a sample in the same cycle
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i || capture_clr_i) begin
            data_words_o <= '0;
        end else if (adc_valid_i) begin
            data_words_o <= word_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fmc_csr.sv ====
`default_nettype none

module fmc_csr (
    input  wire                                   wb_clk_i,
    input  wire                                   rst_n_i,
    // Bus slave side
    input  wire                                   csr_stb_i,
    input  wire                                   wb_we_i,
    input  wire fmc_pkg::csr_reg_e                wb_reg_i,
    input  wire [wb_pkg::WB_DATA_W-1:0]           wb_dat_i,
    output logic                                  csr_ack_o,
    output logic [wb_pkg::WB_DATA_W-1:0]          csr_dat_o,
    // Card status
    input  wire                                   fmc_prsnt_i,
    input  wire                                   fmc_pg_m2c_i,
    input  wire                                   fmc_pll_status_i,
    input  wire                                   fmc_temp_alarm_i,
    input  wire                                   fmc_trig_val_i,
    // Captured samples
    input  wire [fmc_pkg::ADC_CHANNELS-1:0][fmc_pkg::DATA_WORD_W-1:0] data_words_i,
    // Trigger
    output logic                                  fmc_trig_dir_o,
    output logic                                  fmc_trig_term_o,
    output logic                                  fmc_trig_val_o,
    // ADC control pins
    output logic                                  fmc_adc_rand_o,
    output logic                                  fmc_adc_dith_o,
    output logic                                  fmc_adc_shdn_o,
    output logic                                  fmc_adc_pga_o,
    // Clock distribution
    output logic                                  fmc_si571_oe_o,
    output logic                                  fmc_pll_function_o,
    output logic                                  fmc_clk_sel_o,
    // LEDs
    output logic                                  fmc_led1_o,
    output logic                                  fmc_led2_o,
    output logic                                  fmc_led3_o,
    output logic                                  board_led1_o,
    output logic                                  board_led2_o,
    output logic                                  board_led3_o,
    output logic                                  capture_clr_o
);

    import wb_pkg::*;
    import fmc_pkg::*;

    logic                 ack_q;
    logic                 wr_en;
    logic [WB_DATA_W-1:0] rd_data;
    logic [WB_DATA_W-1:0] dat_q;
    logic                 trig_dir_q;
    logic                 trig_term_q;
    logic                 trig_val_q;
    logic                 adc_rand_q;
    logic                 adc_dith_q;
    logic                 adc_shdn_q;
    logic                 adc_pga_q;
    logic                 si571_oe_q;
    logic                 pll_func_q;
    logic                 clk_sel_q;
    logic                 led1_q;
    logic                 led2_q;
    logic                 led3_q;
    logic                 capture_clr_q;

    // ========================================================================
    // Handshake
    // ========================================================================
    // New access only when not already answering the held strobe
    assign wr_en = csr_stb_i && wb_we_i && !ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= csr_stb_i && !ack_q;
        end
    end

    // Read data lands together with the ack
    always_ff @(posedge wb_clk_i) begin
        if (csr_stb_i && !ack_q) begin
            dat_q <= rd_data;
        end
    end

    // ========================================================================
    // Control registers
    // ========================================================================
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            trig_dir_q    <= 1'b0;
            trig_term_q   <= 1'b0;
            trig_val_q    <= 1'b0;
            adc_rand_q    <= 1'b0;
            adc_dith_q    <= 1'b0;
            adc_shdn_q    <= 1'b0;
            adc_pga_q     <= 1'b0;
            si571_oe_q    <= 1'b0;
            pll_func_q    <= 1'b0;
            clk_sel_q     <= 1'b0;
            led1_q        <= 1'b0;
            led2_q        <= 1'b0;
            led3_q        <= 1'b0;
            capture_clr_q <= 1'b0;
        end else begin
            // Self-clearing, one cycle wide
            capture_clr_q <= wr_en && (wb_reg_i == FPGA_CTRL)
                             && wb_dat_i[FPGA_CAPTURE_CLR_BIT];
            if (wr_en) begin
                case (wb_reg_i)
                    TRIGGER: begin
                        trig_dir_q  <= wb_dat_i[TRIG_DIR_BIT];
                        trig_term_q <= wb_dat_i[TRIG_TERM_BIT];
                        trig_val_q  <= wb_dat_i[TRIG_VAL_BIT];
                    end
                    ADC_CTRL: begin
                        adc_rand_q <= wb_dat_i[ADC_RAND_BIT];
                        adc_dith_q <= wb_dat_i[ADC_DITH_BIT];
                        adc_shdn_q <= wb_dat_i[ADC_SHDN_BIT];
                        adc_pga_q  <= wb_dat_i[ADC_PGA_BIT];
                    end
                    CLK_DISTRIB: begin
                        si571_oe_q <= wb_dat_i[CLK_SI571_OE_BIT];
                        pll_func_q <= wb_dat_i[CLK_PLL_FUNC_BIT];
                        clk_sel_q  <= wb_dat_i[CLK_SEL_BIT];
                    end
                    MONITOR: begin
                        led1_q <= wb_dat_i[MON_LED1_BIT];
                        led2_q <= wb_dat_i[MON_LED2_BIT];
                        led3_q <= wb_dat_i[MON_LED3_BIT];
                    end
                    // Status, id and data words are read only
                    default: begin
                    end
                endcase
            end
        end
    end

    // ========================================================================
    // Read mux
    // ========================================================================
    always_comb begin
        rd_data = '0;
        case (wb_reg_i)
            FMC_STATUS: begin
                rd_data[STATUS_PRSNT_BIT] = fmc_prsnt_i;
                rd_data[STATUS_PG_BIT]    = fmc_pg_m2c_i;
            end
            FW_ID: rd_data = FIRMWARE_ID;
            TRIGGER: begin
                rd_data[TRIG_DIR_BIT]  = trig_dir_q;
                rd_data[TRIG_TERM_BIT] = trig_term_q;
                rd_data[TRIG_VAL_BIT]  = trig_val_q;
            end
            ADC_CTRL: begin
                rd_data[ADC_RAND_BIT] = adc_rand_q;
                rd_data[ADC_DITH_BIT] = adc_dith_q;
                rd_data[ADC_SHDN_BIT] = adc_shdn_q;
                rd_data[ADC_PGA_BIT]  = adc_pga_q;
            end
            CLK_DISTRIB: begin
                rd_data[CLK_SI571_OE_BIT]   = si571_oe_q;
                rd_data[CLK_PLL_FUNC_BIT]   = pll_func_q;
                rd_data[CLK_PLL_STATUS_BIT] = fmc_pll_status_i;
                rd_data[CLK_SEL_BIT]        = clk_sel_q;
            end
            MONITOR: begin
                rd_data[MON_TEMP_ALARM_BIT] = fmc_temp_alarm_i;
                rd_data[MON_LED1_BIT]       = led1_q;
                rd_data[MON_LED2_BIT]       = led2_q;
                rd_data[MON_LED3_BIT]       = led3_q;
            end
            DATA0: rd_data = data_words_i[0];
            DATA1: rd_data = data_words_i[1];
            DATA2: rd_data = data_words_i[2];
            DATA3: rd_data = data_words_i[3];
            // FPGA_CTRL and holes above DATA3 read zero
            default: rd_data = '0;
        endcase
    end

    assign csr_ack_o = ack_q;
    assign csr_dat_o = dat_q;

    assign fmc_trig_dir_o     = trig_dir_q;
    assign fmc_trig_term_o    = trig_term_q;
    assign fmc_trig_val_o     = trig_val_q;
    assign fmc_adc_rand_o     = adc_rand_q;
    assign fmc_adc_dith_o     = adc_dith_q;
    assign fmc_adc_shdn_o     = adc_shdn_q;
    assign fmc_adc_pga_o      = adc_pga_q;
    assign fmc_si571_oe_o     = si571_oe_q;
    assign fmc_pll_function_o = pll_func_q;
    assign fmc_clk_sel_o      = clk_sel_q;
    assign capture_clr_o      = capture_clr_q;

    // LED1 on the card also blinks with the incoming trigger
    assign fmc_led1_o   = led1_q || fmc_trig_val_i;
    assign fmc_led2_o   = led2_q;
    assign fmc_led3_o   = led3_q;
    // Board LEDs show the register bits only
    assign board_led1_o = led1_q;
    assign board_led2_o = led2_q;
    assign board_led3_o = led3_q;

endmodule

`default_nettype wire

// ==== verilog/fmc_adc_top.sv ====
`default_nettype none

module fmc_adc_top (
    input  wire                                   wb_clk_i,
    input  wire                                   rst_n_i,
    // Bus from the external master
    input  wire                                   wb_cyc_i,
    input  wire                                   wb_stb_i,
    input  wire                                   wb_we_i,
    input  wire [wb_pkg::WB_ADDR_W-1:0]           wb_adr_i,
    input  wire [wb_pkg::WB_DATA_W-1:0]           wb_dat_i,
    output logic [wb_pkg::WB_DATA_W-1:0]          wb_dat_o,
    output logic                                  wb_ack_o,
    output logic                                  wb_err_o,
    // ADC samples, already in the bus clock domain
    input  wire [fmc_pkg::ADC_CHANNELS-1:0][fmc_pkg::ADC_SAMPLE_W-1:0] adc_data_i,
    input  wire [fmc_pkg::ADC_CHANNELS-1:0]       adc_of_i,
    input  wire                                   adc_valid_i,
    // Card status
    input  wire                                   fmc_prsnt_i,
    input  wire                                   fmc_pg_m2c_i,
    input  wire                                   fmc_pll_status_i,
    input  wire                                   fmc_temp_alarm_i,
    input  wire                                   fmc_trig_val_i,
    // Card control
    output logic                                  fmc_trig_dir_o,
    output logic                                  fmc_trig_term_o,
    output logic                                  fmc_trig_val_o,
    output logic                                  fmc_adc_rand_o,
    output logic                                  fmc_adc_dith_o,
    output logic                                  fmc_adc_shdn_o,
    output logic                                  fmc_adc_pga_o,
    output logic                                  fmc_si571_oe_o,
    output logic                                  fmc_pll_function_o,
    output logic                                  fmc_clk_sel_o,
    output logic                                  fmc_led1_o,
    output logic                                  fmc_led2_o,
    output logic                                  fmc_led3_o,
    output logic                                  board_led1_o,
    output logic                                  board_led2_o,
    output logic                                  board_led3_o
);

    import wb_pkg::*;
    import fmc_pkg::*;

    logic                                     csr_stb;
    logic                                     csr_ack;
    logic [WB_DATA_W-1:0]                     csr_dat;
    logic                                     capture_clr;
    logic [ADC_CHANNELS-1:0][DATA_WORD_W-1:0] data_words;

    // ========================================================================
    // Region decode
    // ========================================================================
    wb_addr_decode i_addr_decode (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_adr_i  (wb_adr_i[WB_ADDR_W-1 -: WB_REGION_W]),
        .csr_ack_i (csr_ack),
        .csr_dat_i (csr_dat),
        .csr_stb_o (csr_stb),
        .wb_ack_o  (wb_ack_o),
        .wb_err_o  (wb_err_o),
        .wb_dat_o  (wb_dat_o)
    );

    // Card registers at region 5
    fmc_csr i_fmc_csr (
        .wb_clk_i           (wb_clk_i),
        .rst_n_i            (rst_n_i),
        .csr_stb_i          (csr_stb),
        .wb_we_i            (wb_we_i),
        .wb_reg_i           (csr_reg_e'(wb_adr_i[CSR_REG_LSB +: $bits(csr_reg_e)])),
        .wb_dat_i           (wb_dat_i),
        .csr_ack_o          (csr_ack),
        .csr_dat_o          (csr_dat),
        .fmc_prsnt_i        (fmc_prsnt_i),
        .fmc_pg_m2c_i       (fmc_pg_m2c_i),
        .fmc_pll_status_i   (fmc_pll_status_i),
        .fmc_temp_alarm_i   (fmc_temp_alarm_i),
        .fmc_trig_val_i     (fmc_trig_val_i),
        .data_words_i       (data_words),
        .fmc_trig_dir_o     (fmc_trig_dir_o),
        .fmc_trig_term_o    (fmc_trig_term_o),
        .fmc_trig_val_o     (fmc_trig_val_o),
        .fmc_adc_rand_o     (fmc_adc_rand_o),
        .fmc_adc_dith_o     (fmc_adc_dith_o),
        .fmc_adc_shdn_o     (fmc_adc_shdn_o),
        .fmc_adc_pga_o      (fmc_adc_pga_o),
        .fmc_si571_oe_o     (fmc_si571_oe_o),
        .fmc_pll_function_o (fmc_pll_function_o),
        .fmc_clk_sel_o      (fmc_clk_sel_o),
        .fmc_led1_o         (fmc_led1_o),
        .fmc_led2_o         (fmc_led2_o),
        .fmc_led3_o         (fmc_led3_o),
        .board_led1_o       (board_led1_o),
        .board_led2_o       (board_led2_o),
        .board_led3_o       (board_led3_o),
        .capture_clr_o      (capture_clr)
    );

    // Sample words for DATA0..DATA3
    adc_capture i_adc_capture (
        .wb_clk_i      (wb_clk_i),
        .rst_n_i       (rst_n_i),
        .adc_data_i    (adc_data_i),
        .adc_of_i      (adc_of_i),
        .adc_valid_i   (adc_valid_i),
        .capture_clr_i (capture_clr),
        .data_words_o  (data_words)
    );

endmodule

`default_nettype wire

// ==== bench/tb_fmc_adc_top.sv ====
`default_nettype none

module tb_fmc_adc_top;

    import fmc_pkg::*;

    // Table entry kinds
    localparam logic [1:0] K_ACCESS = 2'd0;
    localparam logic [1:0] K_STATUS = 2'd1;
    localparam logic [1:0] K_SAMPLE = 2'd2;

    // Status field: prsnt, pg, pll status, temp alarm, trigger in
    typedef struct packed {
        logic [1:0]  kind;
        logic        we;
        logic [31:0] adr;
        logic [31:0] wdat;
        logic [31:0] rdat;
        logic        err;
        logic [4:0]  stat;
    } op_t;

    logic             clk;
    logic             rst_n;
    logic             cyc;
    logic             stb;
    logic             we;
    logic [31:0]      adr;
    logic [31:0]      wdat;
    logic [3:0][15:0] adc_data;
    logic [3:0]       adc_of;
    logic             adc_valid;
    logic             prsnt;
    logic             pg;
    logic             pll;
    logic             temp;
    logic             trig_in;
    wire  [31:0]      rdat;
    wire              ack;
    wire              err;
    // Control pins, trigger outputs in the top bits
    wire  [15:0]      pins;

    op_t              ops[$];
    op_t              op;
    logic [3:0][15:0] samp;
    logic [3:0]       samp_of;
    logic [31:0]      seed;
    // Expected register contents
    logic [2:0]       sh_trig;
    logic [3:0]       sh_adc;
    logic [3:0]       sh_clk;
    logic [3:1]       sh_led;
    int               fail_count;
    int               cycles;
    int               timeout_limit;
    int               i;

    fmc_adc_top uut (
        .wb_clk_i (clk), .rst_n_i (rst_n),
        .wb_cyc_i (cyc), .wb_stb_i (stb), .wb_we_i (we),
        .wb_adr_i (adr), .wb_dat_i (wdat), .wb_dat_o (rdat),
        .wb_ack_o (ack), .wb_err_o (err),
        .adc_data_i (adc_data), .adc_of_i (adc_of), .adc_valid_i (adc_valid),
        .fmc_prsnt_i (prsnt), .fmc_pg_m2c_i (pg), .fmc_pll_status_i (pll),
        .fmc_temp_alarm_i (temp), .fmc_trig_val_i (trig_in),
        .fmc_trig_dir_o (pins[15]), .fmc_trig_term_o (pins[14]),
        .fmc_trig_val_o (pins[13]), .fmc_adc_rand_o (pins[12]),
        .fmc_adc_dith_o (pins[11]), .fmc_adc_shdn_o (pins[10]),
        .fmc_adc_pga_o (pins[9]), .fmc_si571_oe_o (pins[8]),
        .fmc_pll_function_o (pins[7]), .fmc_clk_sel_o (pins[6]),
        .fmc_led1_o (pins[5]), .fmc_led2_o (pins[4]), .fmc_led3_o (pins[3]),
        .board_led1_o (pins[2]), .board_led2_o (pins[1]), .board_led3_o (pins[0])
    );

    always #10 clk = ~clk;

    // Run limit scales with the table
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("Run timed out after %0d cycles before the table finished", cycles);
            $display("TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    // ========================================================================
    // Helpers
    // ========================================================================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] csr_addr(input logic [3:0] off);
        return {16'h0005, 10'd0, off, 2'b00};
    endfunction

    function automatic logic [31:0] region_addr(input logic [15:0] r);
        return {r, 16'h0000};
    endfunction

    // Pin image from the register model, LED1 ORed with trigger
    function automatic logic [15:0] expected_pins();
        return {sh_trig[0], sh_trig[1], sh_trig[2],
                sh_adc[0], sh_adc[1], sh_adc[2], sh_adc[3],
                sh_clk[0], sh_clk[1], sh_clk[3],
                sh_led[1] | trig_in, sh_led[2], sh_led[3],
                sh_led[1], sh_led[2], sh_led[3]};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            fail_count++;
            $display("FAIL %s: expected 0x%08h, got 0x%08h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Writable bits only, read-only bits come from the inputs
    task automatic update_model(input logic [3:0] off, input logic [31:0] d);
        case (off)
            TRIGGER: begin
                sh_trig = d[2:0];
            end
            ADC_CTRL: begin
                sh_adc = d[3:0];
            end
            CLK_DISTRIB: begin
                sh_clk = {d[3], 1'b0, d[1:0]};
            end
            MONITOR: begin
                sh_led = d[3:1];
            end
            default: begin
            end
        endcase
    endtask

    task automatic add_access(input logic w, input logic [31:0] a, input logic [31:0] d,
                              input logic [31:0] r, input logic e);
        op_t n;
        n = '0;
        n.kind = K_ACCESS;
        n.we = w;
        n.adr = a;
        n.wdat = d;
        n.rdat = r;
        n.err = e;
        ops.push_back(n);
    endtask

    task automatic add_other(input logic [1:0] k, input logic [4:0] s);
        op_t n;
        n = '0;
        n.kind = k;
        n.stat = s;
        ops.push_back(n);
    endtask

    // ========================================================================
    // Bus and input drivers
    // ========================================================================
    task automatic do_access(input op_t o);
        int waited;
        waited = 0;
        @(posedge clk);
        cyc  <= 1'b1;
        stb  <= 1'b1;
        we   <= o.we;
        adr  <= o.adr;
        wdat <= o.wdat;
        // Outputs sampled on the falling edge
        do begin
            @(negedge clk);
            waited++;
        end while (!ack && !err);
        // Count includes the strobe cycle itself
        compare_value("response latency", 32'd2, 32'(waited));
        compare_value("wb_err_o", 32'(o.err), 32'(err));
        compare_value("wb_ack_o", 32'(!o.err), 32'(ack));
        if (!o.err && !o.we) begin
            compare_value("wb_dat_o", o.rdat, rdat);
        end
        if (!o.err && o.we) begin
            update_model(o.adr[5:2], o.wdat);
        end
        compare_value("control pins", 32'(expected_pins()), 32'(pins));
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        // Single pulse per access
        @(negedge clk);
        compare_value("wb_ack_o after response", 32'd0, 32'(ack));
        compare_value("wb_err_o after response", 32'd0, 32'(err));
    endtask

    task automatic apply_status(input logic [4:0] s);
        @(posedge clk);
        {prsnt, pg, pll, temp, trig_in} <= s;
        @(negedge clk);
        compare_value("control pins", 32'(expected_pins()), 32'(pins));
    endtask

    task automatic apply_sample();
        @(posedge clk);
        adc_data  <= samp;
        adc_of    <= samp_of;
        adc_valid <= 1'b1;
        @(posedge clk);
        adc_valid <= 1'b0;
    endtask

    // ========================================================================
    // Operation table
    // ========================================================================
    task automatic build_table();
        int k;
        // Reset values
        add_access(1'b0, csr_addr(FMC_STATUS), '0, 32'h0, 1'b0);
        add_access(1'b0, csr_addr(FW_ID), '0, 32'h01332A11, 1'b0);
        add_access(1'b0, csr_addr(TRIGGER), '0, 32'h0, 1'b0);
        add_access(1'b0, csr_addr(ADC_CTRL), '0, 32'h0, 1'b0);
        add_access(1'b0, csr_addr(CLK_DISTRIB), '0, 32'h0, 1'b0);
        add_access(1'b0, csr_addr(MONITOR), '0, 32'h0, 1'b0);
        for (k = 0; k < 4; k++) begin
            add_access(1'b0, csr_addr(4'(7 + k)), '0, 32'h0, 1'b0);
        end
        // Write and read back
        add_access(1'b1, csr_addr(TRIGGER), 32'h5, '0, 1'b0);
        add_access(1'b0, csr_addr(TRIGGER), '0, 32'h5, 1'b0);
        add_access(1'b1, csr_addr(TRIGGER), 32'hFFFF_FFFA, '0, 1'b0);
        add_access(1'b0, csr_addr(TRIGGER), '0, 32'h2, 1'b0);
        add_access(1'b1, csr_addr(ADC_CTRL), 32'hA, '0, 1'b0);
        add_access(1'b0, csr_addr(ADC_CTRL), '0, 32'hA, 1'b0);
        add_access(1'b1, csr_addr(ADC_CTRL), 32'h105, '0, 1'b0);
        add_access(1'b0, csr_addr(ADC_CTRL), '0, 32'h5, 1'b0);
        add_access(1'b1, csr_addr(CLK_DISTRIB), 32'hFF, '0, 1'b0);
        add_access(1'b0, csr_addr(CLK_DISTRIB), '0, 32'hB, 1'b0);
        add_access(1'b1, csr_addr(MONITOR), 32'hF, '0, 1'b0);
        add_access(1'b0, csr_addr(MONITOR), '0, 32'hE, 1'b0);
        // Status inputs and trigger into LED1
        add_other(K_STATUS, 5'b11110);
        add_access(1'b0, csr_addr(FMC_STATUS), '0, 32'h3, 1'b0);
        add_access(1'b0, csr_addr(CLK_DISTRIB), '0, 32'hF, 1'b0);
        add_access(1'b0, csr_addr(MONITOR), '0, 32'hF, 1'b0);
        add_other(K_STATUS, 5'b10001);
        add_access(1'b0, csr_addr(FMC_STATUS), '0, 32'h1, 1'b0);
        add_access(1'b0, csr_addr(CLK_DISTRIB), '0, 32'hB, 1'b0);
        add_access(1'b1, csr_addr(MONITOR), 32'h4, '0, 1'b0);
        add_access(1'b0, csr_addr(MONITOR), '0, 32'h4, 1'b0);
        add_other(K_STATUS, 5'b01000);
        add_access(1'b0, csr_addr(FMC_STATUS), '0, 32'h2, 1'b0);
        add_access(1'b1, csr_addr(MONITOR), 32'h2, '0, 1'b0);
        add_other(K_STATUS, 5'b00101);
        add_access(1'b0, csr_addr(CLK_DISTRIB), '0, 32'hF, 1'b0);
        add_other(K_STATUS, 5'b00000);
        // Dropped and unknown regions
        for (k = 1; k <= 4; k++) begin
            add_access(1'b0, region_addr(16'(k)), '0, '0, 1'b1);
            add_access(1'b1, region_addr(16'(k)) | 32'h8, 32'h7, '0, 1'b1);
        end
        add_access(1'b0, region_addr(16'h0000), '0, '0, 1'b1);
        add_access(1'b1, region_addr(16'h0006), 32'h1, '0, 1'b1);
        add_access(1'b0, region_addr(16'hFFFF), '0, '0, 1'b1);
        add_access(1'b0, region_addr(16'h0105), '0, '0, 1'b1);
        // Holes above DATA3
        add_access(1'b0, csr_addr(4'd11), '0, 32'h0, 1'b0);
        add_access(1'b0, csr_addr(4'd15), '0, 32'h0, 1'b0);
        add_access(1'b1, csr_addr(4'd12), 32'hFFFF_FFFF, '0, 1'b0);
        add_access(1'b0, csr_addr(TRIGGER), '0, 32'h2, 1'b0);
        // Capture then clear
        add_other(K_SAMPLE, 5'b00000);
        for (k = 0; k < 4; k++) begin
            add_access(1'b0, csr_addr(4'(7 + k)), '0, {15'd0, samp_of[k], samp[k]}, 1'b0);
        end
        add_access(1'b1, csr_addr(FPGA_CTRL), 32'h1, '0, 1'b0);
        add_access(1'b0, csr_addr(FPGA_CTRL), '0, 32'h0, 1'b0);
        for (k = 0; k < 4; k++) begin
            add_access(1'b0, csr_addr(4'(7 + k)), '0, 32'h0, 1'b0);
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        wdat = '0;
        adc_data = '0;
        adc_of = '0;
        adc_valid = 1'b0;
        {prsnt, pg, pll, temp, trig_in} = 5'b00000;
        {sh_trig, sh_adc, sh_clk, sh_led} = '0;
        fail_count = 0;
        cycles = 0;
        timeout_limit = 200;
        // Samples and overflow flags from the LCG
        seed = 32'hc65c_047c;
        for (i = 0; i < 4; i++) begin
            seed = lcg_next(seed);
            samp[i] = seed[31:16];
            samp_of[i] = seed[15];
        end
        build_table();
        timeout_limit = 10 * ops.size() + 200;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_value("control pins after reset", 32'h0, 32'(pins));
        compare_value("wb_ack_o after reset", 32'h0, 32'(ack));
        compare_value("wb_err_o after reset", 32'h0, 32'(err));
        for (i = 0; i < ops.size(); i++) begin
            op = ops[i];
            case (op.kind)
                K_ACCESS: do_access(op);
                K_STATUS: apply_status(op.stat);
                default: apply_sample();
            endcase
        end
        if (fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "Run ended with errors");
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/wb_pkg.sv
verilog/fmc_pkg.sv
verilog/wb_addr_decode.sv
verilog/adc_capture.sv
verilog/fmc_csr.sv
verilog/fmc_adc_top.sv
bench/tb_fmc_adc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_fmc_adc_top -f src.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TESTS PASSED$" sim.log && echo "Simulation run ok" \
    || { echo "Simulation run not ok"; exit 1; }
